// ==== flist.f ====
rtl/vec_pkg.sv
rtl/vec_dispatcher.sv
rtl/vec_sequencer.sv
rtl/vec_lane.sv
rtl/vec_retire.sv
rtl/vec_top.sv
testbench/vec_checker.sv
testbench/tb_vec_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vec_top -f flist.f --Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/vsim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// ==== testbench/tb_vec_top.sv ====
// Directed tests only and every register is written at full vl before any of its elements is read
`timescale 1ns/1ps

module tb_vec_top import vec_pkg::*; ;

  localparam int MaxCycles = 4000;

  logic      clk_i;
  logic      arst_n_i;
  logic      req_valid_i;
  vec_req_t  req_i;
  logic      req_ready_o;
  logic      resp_valid_o;
  vec_resp_t resp_o;

  int          errors = 0;
  int          cycles = 0;
  logic [31:0] rng = 32'h2ac0_3c50;

  // Reference state indexed by element
  elem_t model_rf [NrVRegs][VlMax];
  vlen_t model_vl;

  vec_top u_dut (
    .clk_i        (clk_i       ),
    .arst_n_i     (arst_n_i    ),
    .req_valid_i  (req_valid_i ),
    .req_i        (req_i       ),
    .req_ready_o  (req_ready_o ),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MaxCycles) begin
      $display("Timeout: no finish after %0d clock cycles, the DUT stopped answering", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic vec_req_t build_req(input vop_e op, input int vd, input int vs1,
                                         input int vs2, input elem_t rs1);
    return '{op: op, vd: vreg_t'(vd), vs1: vreg_t'(vs1), vs2: vreg_t'(vs2), rs1: rs1};
  endfunction

  task automatic check_vl(input vlen_t got, input vlen_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s vl %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_elem(input elem_t got, input elem_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s result %h expected %h", $time, what, got, exp);
    end
  endtask

  // Element-wise reference for one instruction
  task automatic model_apply(input vec_req_t r, output elem_t exp);
    elem_t a;
    elem_t b;
    exp = '0;
    case (r.op)
      VSETVL: begin
        model_vl = (r.rs1 > VlMax) ? vlen_t'(VlMax) : vlen_t'(r.rs1);
        exp      = elem_t'(model_vl);
      end
      VREDSUM: begin
        exp = r.rs1;
        for (int i = 0; i < int'(model_vl); i++) exp = exp + model_rf[r.vs2][i];
      end
      VEXT: exp = model_rf[r.vs2][r.rs1 % VlMax];
      default: begin
        for (int i = 0; i < int'(model_vl); i++) begin
          a = model_rf[r.vs1][i];
          b = model_rf[r.vs2][i];
          case (r.op)
            VMV_VX:  model_rf[r.vd][i] = r.rs1;
            VID:     model_rf[r.vd][i] = elem_t'(i);
            VADD_VV: model_rf[r.vd][i] = b + a;
            VADD_VX: model_rf[r.vd][i] = b + r.rs1;
            VSUB_VV: model_rf[r.vd][i] = b - a;
            VAND_VV: model_rf[r.vd][i] = b & a;
            VOR_VV:  model_rf[r.vd][i] = b | a;
            default: model_rf[r.vd][i] = b ^ a;
          endcase
        end
      end
    endcase
  endtask

  // Issue one request, wait for its response and compare it with the model
  task automatic run_instr(input vec_req_t r, input bit hold_valid);
    elem_t exp;
    elem_t got;
    int    lat;
    bit    reopened;
    string what;
    req_valid_i = 1'b1;
    req_i       = r;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #2;
    if (!hold_valid) req_valid_i = 1'b0;
    lat      = 0;
    reopened = 1'b0;
    do begin
      @(negedge clk_i);
      lat++;
      // Port must stay closed up to and including the response cycle
      if (req_ready_o) reopened = 1'b1;
    end while (!resp_valid_o);
    got = resp_o.result;
    model_apply(r, exp);
    what = $sformatf("%s vd=%0d vs2=%0d rs1=%0d", r.op.name(), r.vd, r.vs2, r.rs1);
    if (reopened) begin
      errors++;
      $display("Request port reopened at %0t before the response of %s", $time, what);
    end
    if (r.op == VSETVL) begin
      check_vl(vlen_t'(got), model_vl, what);
      check_elem(got >> $bits(vlen_t), '0, {what, " upper bits"});
      if (lat != 1) begin
        errors++;
        $display("[ERROR] %0t: VSETVL answered after %0d cycles, expected 1", $time, lat);
      end
    end else begin
      check_elem(got, exp, what);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic read_back(input int vs2);
    for (int i = 0; i < VlMax; i++) run_instr(build_req(VEXT, 0, 0, vs2, i), 1'b0);
  endtask

  // Pseudo-random contents written at vl of VlMax
  task automatic fill_reg(input int vd);
    rng = xorshift32(rng);
    run_instr(build_req(VID, vd, 0, 0, 0), 1'b0);
    run_instr(build_req(VADD_VX, vd, 0, vd, rng), 1'b0);
    rng = xorshift32(rng);
    run_instr(build_req(VMV_VX, 7, 0, 0, rng), 1'b0);
    run_instr(build_req(VXOR_VV, vd, 7, vd, 0), 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic setvl_clamping();
    elem_t lens[6];
    rng  = xorshift32(rng);
    lens = '{0, VlMax, VlMax + 1, 32'hffff_ffff, rng % 48, rng};
    foreach (lens[k]) run_instr(build_req(VSETVL, 0, 0, 0, lens[k]), 1'b0);
  endtask

  task automatic broadcast_and_index();
    run_instr(build_req(VSETVL, 0, 0, 0, VlMax), 1'b0);
    rng = xorshift32(rng);
    run_instr(build_req(VMV_VX, 0, 0, 0, rng), 1'b0);
    read_back(0);
    run_instr(build_req(VID, 1, 0, 0, 0), 1'b0);
    read_back(1);
  endtask

  task automatic vector_ops_with_tail();
    vop_e ops[6];
    ops = '{VADD_VV, VADD_VX, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV};
    run_instr(build_req(VSETVL, 0, 0, 0, VlMax), 1'b0);
    fill_reg(2);
    fill_reg(3);
    rng = xorshift32(rng);
    run_instr(build_req(VMV_VX, 4, 0, 0, rng), 1'b0);
    foreach (ops[k]) begin
      rng = xorshift32(rng);
      run_instr(build_req(VSETVL, 0, 0, 0, rng % (VlMax + 1)), 1'b0);
      rng = xorshift32(rng);
      run_instr(build_req(ops[k], 4, 2, 3, rng), 1'b0);
      read_back(4);
    end
  endtask

  task automatic sum_reduction();
    elem_t lens[5];
    rng  = xorshift32(rng);
    lens = '{0, 1, 5, VlMax, rng % (VlMax + 1)};
    foreach (lens[k]) begin
      run_instr(build_req(VSETVL, 0, 0, 0, lens[k]), 1'b0);
      rng = xorshift32(rng);
      run_instr(build_req(VREDSUM, 0, 0, 4, rng), 1'b0);
    end
  endtask

  // req_valid_i stays high from one request to the next
  task automatic back_to_back_requests();
    run_instr(build_req(VSETVL, 0, 0, 0, VlMax), 1'b1);
    run_instr(build_req(VADD_VV, 5, 2, 3, 0), 1'b1);
    run_instr(build_req(VEXT, 0, 0, 5, VlMax - 1), 1'b1);
    rng = xorshift32(rng);
    run_instr(build_req(VSETVL, 0, 0, 0, rng % (VlMax + 1)), 1'b1);
    run_instr(build_req(VSUB_VV, 5, 4, 3, 0), 1'b1);
    rng = xorshift32(rng);
    run_instr(build_req(VREDSUM, 0, 0, 5, rng), 1'b1);
    run_instr(build_req(VEXT, 0, 0, 5, rng % VlMax), 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    model_vl    = '0;
    repeat (3) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #2;
    if (!req_ready_o || resp_valid_o) begin
      errors++;
      $display("After reset the request port is not open or a response is pending");
    end

    setvl_clamping();
    broadcast_and_index();
    vector_ops_with_tail();
    sum_reduction();
    back_to_back_requests();

    repeat (2) @(posedge clk_i);
    $display("Finished after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/vec_checker.sv ====
// Watches only the core-side ports of vec_top and is silent while reset is asserted
`timescale 1ns/1ps

module vec_checker import vec_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      req_valid_i,
  input logic      req_ready_o,
  input logic      resp_valid_o,
  input vec_resp_t resp_o
);

  // Response only while the port is closed
  a_resp_while_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o |-> !req_ready_o)
    else $error("response strobe seen while req_ready_o is high");

  a_accept_closes: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_valid_i && req_ready_o) |=> !req_ready_o)
    else $error("req_ready_o stayed high after an accepted request");

  a_resp_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o |=> !resp_valid_o)
    else $error("resp_valid_o held for more than one cycle");

  a_resp_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o |-> !$isunknown(resp_o))
    else $error("resp_o has unknown bits while valid");

endmodule

bind vec_top vec_checker u_checker (.*);

// ==== rtl/vec_top.sv ====
// Nothing stalls inside the unit, so the core must take every response strobe when it comes
`timescale 1ns/1ps

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  input  vec_req_t  req_i,
  output logic      req_ready_o,
  output logic      resp_valid_o,
  output vec_resp_t resp_o
);

  logic                    instr_valid;
  seq_req_t                instr;
  logic                    beat_valid;
  beat_t                   beat;
  lane_res_t [NrLanes-1:0] lane_res;
  logic                    ctrl_valid;
  beat_t                   ctrl;
  logic                    done;
  elem_t                   done_scalar;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher and sequencer

  vec_dispatcher u_dispatcher (
    .clk_i         (clk_i        ),
    .arst_n_i      (arst_n_i     ),
    .req_valid_i   (req_valid_i  ),
    .req_i         (req_i        ),
    .req_ready_o   (req_ready_o  ),
    .resp_valid_o  (resp_valid_o ),
    .resp_o        (resp_o       ),
    .instr_valid_o (instr_valid  ),
    .instr_o       (instr        ),
    .done_i        (done         ),
    .done_scalar_i (done_scalar  )
  );

  vec_sequencer u_sequencer (
    .clk_i         (clk_i        ),
    .arst_n_i      (arst_n_i     ),
    .instr_valid_i (instr_valid  ),
    .instr_i       (instr        ),
    .beat_valid_o  (beat_valid   ),
    .beat_o        (beat         )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes

  // Lane 0 alone carries the beat control on to retire
  for (genvar g = 0; g < NrLanes; g++) begin : gen_lanes
    if (g == 0) begin : gen_ctrl
      vec_lane #(.LaneId(g)) u_lane (
        .clk_i        (clk_i       ),
        .arst_n_i     (arst_n_i    ),
        .beat_valid_i (beat_valid  ),
        .beat_i       (beat        ),
        .res_o        (lane_res[g] ),
        .ctrl_valid_o (ctrl_valid  ),
        .ctrl_o       (ctrl        )
      );
    end else begin : gen_plain
      vec_lane #(.LaneId(g)) u_lane (
        .clk_i        (clk_i       ),
        .arst_n_i     (arst_n_i    ),
        .beat_valid_i (beat_valid  ),
        .beat_i       (beat        ),
        .res_o        (lane_res[g] ),
        .ctrl_valid_o (            ),
        .ctrl_o       (            )
      );
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Retire

  vec_retire u_retire (
    .clk_i         (clk_i        ),
    .arst_n_i      (arst_n_i     ),
    .ctrl_valid_i  (ctrl_valid   ),
    .ctrl_i        (ctrl         ),
    .res_i         (lane_res     ),
    .done_o        (done         ),
    .done_scalar_o (done_scalar  )
  );

endmodule

// ==== rtl/vec_retire.sv ====
// Beats of one instruction arrive in order with first and last marked, and there is no back-pressure
`timescale 1ns/1ps

module vec_retire import vec_pkg::*; (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    ctrl_valid_i,
  input  beat_t                   ctrl_i,
  input  lane_res_t [NrLanes-1:0] res_i,
  output logic                    done_o,
  output elem_t                   done_scalar_o
);

  elem_t acc_q;
  elem_t beat_sum;
  elem_t acc_base;
  elem_t acc_next;

  // Sum of the enabled lanes in this beat
  always_comb begin
    beat_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      if (res_i[l].en) begin
        beat_sum = beat_sum + res_i[l].data;
      end
    end
  end

  // The reduction seeds from rs1, everything else from zero
  always_comb begin
    if (!ctrl_i.first) begin
      acc_base = acc_q;
    end else if (ctrl_i.op == VREDSUM) begin
      acc_base = ctrl_i.scalar;
    end else begin
      acc_base = '0;
    end
    acc_next = acc_base + beat_sum;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= ctrl_valid_i & ctrl_i.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_valid_i) begin
      acc_q <= acc_next;
      if (ctrl_i.last) begin
        done_scalar_o <= (ctrl_i.op inside {VREDSUM, VEXT}) ? acc_next : '0;
      end
    end
  end

endmodule

// ==== rtl/vec_lane.sv ====
// Register slice has no reset, so a register must be written before its elements are read
`timescale 1ns/1ps

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      beat_valid_i,
  input  beat_t     beat_i,
  output lane_res_t res_o,
  // Beat control as seen in the execute stage
  output logic      ctrl_valid_o,
  output beat_t     ctrl_o
);

  // Rows of every register that map to this lane
  elem_t rf_q [NrVRegs][RowsPerReg];

  logic  rd_valid_q;
  beat_t rd_beat_q;
  logic  ex_valid_q;
  beat_t ex_beat_q;
  elem_t ex_a_q;
  elem_t ex_b_q;
  elem_t alu_res;
  logic  ex_en;
  logic  wr_en;

  ////////////////////////////////////////////////////////////////////////////
  // Read stage

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_valid_q <= 1'b0;
      ex_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= beat_valid_i;
      ex_valid_q <= rd_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_beat_q <= beat_i;
    ex_beat_q <= rd_beat_q;
    ex_a_q    <= rf_q[rd_beat_q.vs1][rd_beat_q.row];
    ex_b_q    <= rf_q[rd_beat_q.vs2][rd_beat_q.row];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Execute and writeback

  // a is vs1, b is vs2
  always_comb begin
    case (ex_beat_q.op)
      VMV_VX:  alu_res = ex_beat_q.scalar;
      VID:     alu_res = elem_t'({ex_beat_q.row, LaneIdxW'(LaneId)});
      VADD_VV: alu_res = ex_b_q + ex_a_q;
      VADD_VX: alu_res = ex_b_q + ex_beat_q.scalar;
      VSUB_VV: alu_res = ex_b_q - ex_a_q;
      VAND_VV: alu_res = ex_b_q & ex_a_q;
      VOR_VV:  alu_res = ex_b_q | ex_a_q;
      VXOR_VV: alu_res = ex_b_q ^ ex_a_q;
      // Reduction and extraction pass vs2 on to retire
      default: alu_res = ex_b_q;
    endcase
  end

  assign ex_en = ex_valid_q & ex_beat_q.lane_en[LaneId];
  assign wr_en = ex_en & !(ex_beat_q.op inside {VREDSUM, VEXT});

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      rf_q[ex_beat_q.vd][ex_beat_q.row] <= alu_res;
    end
  end

  assign res_o        = '{en: ex_en, data: alu_res};
  assign ctrl_valid_o = ex_valid_q;
  assign ctrl_o       = ex_beat_q;

endmodule

// ==== rtl/vec_sequencer.sv ====
// Takes a new instruction only while idle, and the VEXT index is used modulo VlMax
`timescale 1ns/1ps

module vec_sequencer import vec_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     instr_valid_i,
  input  seq_req_t instr_i,
  output logic     beat_valid_o,
  output beat_t    beat_o
);

  typedef enum logic {
    SeqIdle,
    SeqIssue
  } seq_state_e;

  seq_state_e state_q;
  seq_req_t   cur_q;
  row_t       row_q;
  row_t       last_row_q;
  logic       first_q;
  row_t       start_row;
  row_t       end_row;
  lane_en_t   lane_en;

  // Row range of the new instruction
  always_comb begin
    if (instr_i.req.op == VEXT) begin
      start_row = instr_i.req.rs1[LaneIdxW +: RowIdxW];
      end_row   = start_row;
    end else begin
      start_row = '0;
      end_row   = (instr_i.vl == '0) ? '0 : row_t'((instr_i.vl - 1'b1) >> LaneIdxW);
    end
  end

  // Lane enables for the current row
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      if (cur_q.req.op == VEXT) begin
        lane_en[l] = (cur_q.req.rs1[LaneIdxW-1:0] == LaneIdxW'(l));
      end else begin
        lane_en[l] = (vlen_t'({row_q, LaneIdxW'(l)}) < cur_q.vl);
      end
    end
  end

  assign beat_valid_o = (state_q == SeqIssue);
  assign beat_o = '{op: cur_q.req.op, vd: cur_q.req.vd, vs1: cur_q.req.vs1,
                    vs2: cur_q.req.vs2, scalar: cur_q.req.rs1, row: row_q,
                    lane_en: lane_en, first: first_q, last: (row_q == last_row_q)};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= SeqIdle;
      row_q      <= '0;
      last_row_q <= '0;
      first_q    <= 1'b0;
    end else begin
      case (state_q)
        SeqIdle: begin
          if (instr_valid_i) begin
            state_q    <= SeqIssue;
            row_q      <= start_row;
            last_row_q <= end_row;
            first_q    <= 1'b1;
          end
        end
        SeqIssue: begin
          first_q <= 1'b0;
          row_q   <= row_q + 1'b1;
          if (row_q == last_row_q) begin
            state_q <= SeqIdle;
          end
        end
        default: state_q <= SeqIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && state_q == SeqIdle) begin
      cur_q <= instr_i;
    end
  end

endmodule

// ==== rtl/vec_dispatcher.sv ====
// One instruction in flight and the request port stays closed until the cycle after the response
`timescale 1ns/1ps

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Core request
  input  logic      req_valid_i,
  input  vec_req_t  req_i,
  output logic      req_ready_o,
  // Core response, strobe only
  output logic      resp_valid_o,
  output vec_resp_t resp_o,
  // To the sequencer
  output logic      instr_valid_o,
  output seq_req_t  instr_o,
  // From the retire stage
  input  logic      done_i,
  input  elem_t     done_scalar_i
);

  logic  busy_q;
  vlen_t vl_q;
  vlen_t new_vl;
  logic  req_fire;
  logic  is_setvl;

  assign req_ready_o = ~busy_q;
  assign req_fire    = req_valid_i & req_ready_o;
  assign is_setvl    = (req_i.op == VSETVL);

  // Clamp the requested length to VlMax
  assign new_vl = (req_i.rs1 > elem_t'(VlMax)) ? vlen_t'(VlMax) : vlen_t'(req_i.rs1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q        <= 1'b0;
      vl_q          <= '0;
      resp_valid_o  <= 1'b0;
      instr_valid_o <= 1'b0;
    end else begin
      resp_valid_o  <= 1'b0;
      instr_valid_o <= 1'b0;
      if (req_fire) begin
        busy_q <= 1'b1;
        if (is_setvl) begin
          // Completes here, no trip through the lanes
          vl_q         <= new_vl;
          resp_valid_o <= 1'b1;
        end else begin
          instr_valid_o <= 1'b1;
        end
      end else if (done_i) begin
        resp_valid_o <= 1'b1;
      end else if (resp_valid_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      instr_o <= '{req: req_i, vl: vl_q};
    end
    if (req_fire && is_setvl) begin
      resp_o.result <= elem_t'(new_vl);
    end else if (done_i) begin
      resp_o.result <= done_scalar_i;
    end
  end

endmodule

// ==== rtl/vec_pkg.sv ====
// Lane and row counts must be powers of two so that element indices split into plain bit fields
package vec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes

  localparam int unsigned NrLanes    = 4;
  localparam int unsigned ElemWidth  = 32;
  localparam int unsigned NrVRegs    = 8;
  localparam int unsigned RowsPerReg = 8;
  localparam int unsigned VlMax      = NrLanes * RowsPerReg;

  // Index widths derived from the sizes above
  localparam int unsigned LaneIdxW = $clog2(NrLanes);
  localparam int unsigned RowIdxW  = $clog2(RowsPerReg);

  typedef logic [ElemWidth-1:0]         elem_t;
  typedef logic [$clog2(VlMax+1)-1:0]   vlen_t;
  typedef logic [$clog2(NrVRegs)-1:0]   vreg_t;
  typedef logic [RowIdxW-1:0]           row_t;
  typedef logic [NrLanes-1:0]           lane_en_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes

  typedef enum logic [3:0] {
    VSETVL,
    VMV_VX,   // broadcast rs1
    VID,
    VADD_VV,
    VADD_VX,
    VSUB_VV,  // vs2 - vs1
    VAND_VV,
    VOR_VV,
    VXOR_VV,
    VREDSUM,
    VEXT
  } vop_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs

  // Request from the scalar core
  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    elem_t rs1;
  } vec_req_t;

  typedef struct packed {
    elem_t result;
  } vec_resp_t;

  // Accepted instruction with the vl it runs under
  typedef struct packed {
    vec_req_t req;
    vlen_t    vl;
  } seq_req_t;

  // One beat, broadcast to all lanes
  typedef struct packed {
    vop_e     op;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    elem_t    scalar;
    row_t     row;
    lane_en_t lane_en;
    logic     first;
    logic     last;
  } beat_t;

  typedef struct packed {
    logic  en;
    elem_t data;
  } lane_res_t;

endpackage
